//--- design/uart_mem_pkg.sv
// serial memory monitor
// shared types

package uart_mem_pkg;

    // one data byte on the serial line or in memory
    typedef logic [7:0] byte_t;

    // host command bytes
    typedef enum logic [7:0] {
        cmd_write = 8'h57,  // 'W'
        cmd_read  = 8'h52   // 'R'
    } cmd_t;

    // loader frame stages
    typedef enum logic [2:0] {
        idle,        // waiting for a command byte
        addr_hi,
        addr_lo,
        length,
        write_data,  // one memory write per received byte
        read_fetch,  // memory read request
        read_send,   // latch read data, then start tx
        read_wait    // until tx goes idle
    } stage_t;

    // memory request, valid while en is high
    typedef struct packed {
        logic        en;
        logic        we;
        logic [15:0] addr;   // full protocol address
        byte_t       wdata;
    } mem_req_t;

endpackage

//--- design/uart_rx.sv
// 8N1 uart receiver

module uart_rx #(
    parameter int clks_per_bit = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rx,
    output uart_mem_pkg::byte_t rx_data,
    output logic                rx_stb,
    output logic                rx_err
);

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_bits,
        st_stop
    } rx_state_t;

    rx_state_t           state;
    logic [2:0]          sync;     // two sync flops plus one of history
    logic                rx_s;
    logic                rx_fall;
    logic [cnt_w-1:0]    cnt;
    logic [2:0]          bit_idx;
    uart_mem_pkg::byte_t shreg;
    logic                sample;

    assign rx_s    = sync[1];
    assign rx_fall = sync[2] & ~sync[1];                  // start bit leading edge
    assign sample  = (state == st_bits) && (cnt == full_cnt);
    assign rx_data = shreg;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync <= 3'b111;                               // line idles high
        end else begin
            sync <= {sync[1:0], rx};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            rx_stb  <= 1'b0;
            rx_err  <= 1'b0;
        end else begin
            rx_stb <= 1'b0;
            rx_err <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (rx_fall) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (cnt == half_cnt) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? st_idle : st_bits;  // reject glitches
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_bits: begin
                    if (cnt == full_cnt) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (cnt == full_cnt) begin
                        state  <= st_idle;                // mid stop bit
                        rx_stb <= rx_s;
                        rx_err <= ~rx_s;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (sample) begin
            shreg <= {rx_s, shreg[7:1]};
        end
    end

    // one strobe per character, only after all eight data samples
    a_stb_err_excl: assert property (@(posedge clk) disable iff (rst)
        (rx_stb || rx_err) |-> !(rx_stb && rx_err) && bit_idx == 3'd0);

endmodule

//--- design/uart_tx.sv
// 8N1 uart transmitter

module uart_tx #(
    parameter int clks_per_bit = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  uart_mem_pkg::byte_t tx_data,
    input  logic                tx_start,
    output logic                tx,
    output logic                tx_busy
);

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);

    logic [9:0]       shreg;    // stop, data, start
    logic [cnt_w-1:0] cnt;
    logic [3:0]       bit_idx;
    logic             busy;

    assign tx      = shreg[0];
    assign tx_busy = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            shreg   <= '1;                               // idle high
            cnt     <= '0;
            bit_idx <= '0;
            busy    <= 1'b0;
        end else if (!busy) begin
            if (tx_start) begin
                shreg   <= {1'b1, tx_data, 1'b0};
                cnt     <= '0;
                bit_idx <= '0;
                busy    <= 1'b1;
            end
        end else begin
            if (cnt == full_cnt) begin
                cnt     <= '0;
                shreg   <= {1'b1, shreg[9:1]};           // shift in idle level
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd9) begin
                    busy <= 1'b0;                        // end of stop bit
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !tx_busy);

endmodule

//--- design/sram_block.sv
// single-port block RAM
// registered read, old data on write

module sram_block #(
    parameter int mem_addr_bits = 10
) (
    input  logic                   clk,
    input  uart_mem_pkg::mem_req_t mem_req,
    output uart_mem_pkg::byte_t    rdata
);

    localparam int depth = 2 ** mem_addr_bits;

    uart_mem_pkg::byte_t      mem [0:depth-1];
    logic [mem_addr_bits-1:0] idx;

    assign idx = mem_req.addr[mem_addr_bits-1:0];   // address mod depth

    always_ff @(posedge clk) begin
        if (mem_req.en) begin
            if (mem_req.we) begin
                mem[idx] <= mem_req.wdata;
            end
            rdata <= mem[idx];                        // holds until next request
        end
    end

endmodule

//--- design/mem_loader.sv
// frame parser and memory sequencer
// handles write and read command frames

module mem_loader (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_mem_pkg::byte_t    rx_data,
    input  logic                   rx_stb,
    input  logic                   rx_err,
    output uart_mem_pkg::mem_req_t mem_req,
    input  uart_mem_pkg::byte_t    mem_rdata,
    output uart_mem_pkg::byte_t    tx_data,
    output logic                   tx_start,
    input  logic                   tx_busy,
    output logic                   frame_err
);

    uart_mem_pkg::stage_t stage;
    uart_mem_pkg::cmd_t   cmd_q;
    logic [15:0]          addr_q;     // wraps mod memory depth downstream
    uart_mem_pkg::byte_t  len_q;      // bytes left in frame
    logic                 armed;      // read data latched, ready to send
    uart_mem_pkg::byte_t  tx_q;
    logic                 known_cmd;

    assign known_cmd = (rx_data == uart_mem_pkg::cmd_write) ||
                       (rx_data == uart_mem_pkg::cmd_read);

    // requests come straight from the stage
    always_comb begin
        mem_req       = '0;
        mem_req.addr  = addr_q;
        mem_req.wdata = rx_data;
        if (stage == uart_mem_pkg::write_data && rx_stb) begin
            mem_req.en = 1'b1;
            mem_req.we = 1'b1;
        end
        if (stage == uart_mem_pkg::read_fetch) begin
            mem_req.en = 1'b1;
        end
    end

    assign tx_start = (stage == uart_mem_pkg::read_send) && armed && !tx_busy;
    assign tx_data  = tx_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage     <= uart_mem_pkg::idle;
            cmd_q     <= uart_mem_pkg::cmd_write;
            addr_q    <= '0;
            len_q     <= '0;
            armed     <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            frame_err <= rx_err;
            if (rx_err) begin
                stage <= uart_mem_pkg::idle;                 // abandon the frame
                armed <= 1'b0;
            end else begin
                case (stage)
                    uart_mem_pkg::idle: begin
                        if (rx_stb && known_cmd) begin
                            cmd_q <= uart_mem_pkg::cmd_t'(rx_data);
                            stage <= uart_mem_pkg::addr_hi;
                        end
                    end
                    uart_mem_pkg::addr_hi: begin
                        if (rx_stb) begin
                            addr_q[15:8] <= rx_data;
                            stage        <= uart_mem_pkg::addr_lo;
                        end
                    end
                    uart_mem_pkg::addr_lo: begin
                        if (rx_stb) begin
                            addr_q[7:0] <= rx_data;
                            stage       <= uart_mem_pkg::length;
                        end
                    end
                    uart_mem_pkg::length: begin
                        if (rx_stb) begin
                            len_q <= rx_data;
                            if (rx_data == '0) begin
                                stage <= uart_mem_pkg::idle;     // empty frame
                            end else if (cmd_q == uart_mem_pkg::cmd_write) begin
                                stage <= uart_mem_pkg::write_data;
                            end else begin
                                stage <= uart_mem_pkg::read_fetch;
                            end
                        end
                    end
                    uart_mem_pkg::write_data: begin
                        if (rx_stb) begin
                            addr_q <= addr_q + 16'd1;
                            len_q  <= len_q - 8'd1;
                            if (len_q == 8'd1) begin
                                stage <= uart_mem_pkg::idle;
                            end
                        end
                    end
                    uart_mem_pkg::read_fetch: begin
                        addr_q <= addr_q + 16'd1;
                        stage  <= uart_mem_pkg::read_send;
                    end
                    uart_mem_pkg::read_send: begin
                        if (!armed) begin
                            armed <= 1'b1;                       // rdata latched this cycle
                        end else if (!tx_busy) begin
                            armed <= 1'b0;
                            len_q <= len_q - 8'd1;
                            if (len_q == 8'd1) begin
                                stage <= uart_mem_pkg::idle;
                            end else begin
                                stage <= uart_mem_pkg::read_wait;
                            end
                        end
                    end
                    uart_mem_pkg::read_wait: begin
                        if (!tx_busy) begin
                            stage <= uart_mem_pkg::read_fetch;   // byte on the wire done
                        end
                    end
                    default: stage <= uart_mem_pkg::idle;
                endcase
            end
        end
    end

    // read data byte for the transmitter
    always_ff @(posedge clk) begin
        if (stage == uart_mem_pkg::read_send && !armed) begin
            tx_q <= mem_rdata;
        end
    end

    // writes only inside a write frame with bytes still owed
    a_we_in_write: assert property (@(posedge clk) disable iff (rst)
        (mem_req.en && mem_req.we) |-> stage == uart_mem_pkg::write_data &&
            cmd_q == uart_mem_pkg::cmd_write && len_q != '0);

    // each send follows its fetch by two cycles
    a_start_in_send: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> stage == uart_mem_pkg::read_send &&
            $past(stage, 2) == uart_mem_pkg::read_fetch);

endmodule

//--- design/uart_mem_top.sv
// serial memory monitor top level

module uart_mem_top #(
    parameter int clks_per_bit  = 8,
    parameter int mem_addr_bits = 10
) (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    output logic tx,
    output logic frame_err
);

    uart_mem_pkg::byte_t    rx_data;
    logic                   rx_stb;
    logic                   rx_err;
    uart_mem_pkg::mem_req_t mem_req;
    uart_mem_pkg::byte_t    mem_rdata;
    uart_mem_pkg::byte_t    tx_data;
    logic                   tx_start;
    logic                   tx_busy;

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) u_rx (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .rx_data (rx_data),
        .rx_stb  (rx_stb),
        .rx_err  (rx_err)
    );

    mem_loader u_loader (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_stb    (rx_stb),
        .rx_err    (rx_err),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .frame_err (frame_err)
    );

    sram_block #(
        .mem_addr_bits(mem_addr_bits)
    ) u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

//--- test/uart_mem_tb.sv
// serial memory monitor testbench

module uart_mem_tb;

    localparam int cpb       = 8;
    localparam int addr_bits = 10;

    logic clk;
    logic rst;
    logic rx;
    logic tx;
    logic frame_err;

    uart_mem_pkg::byte_t reply_q[$];   // bytes decoded from tx
    logic [7:0]          kind_q[$];
    int                  addr_q[$];
    int                  len_q[$];
    int                  aux_q[$];
    uart_mem_pkg::byte_t data_q[$];    // payload or expected reply of every frame
    int                  err_count = 0;
    int                  cycles = 0;
    int                  limit = 0;

    uart_mem_top #(
        .clks_per_bit  (cpb),
        .mem_addr_bits (addr_bits)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .tx        (tx),
        .frame_err (frame_err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // one 8N1 character on rx, lsb first
    task automatic send_byte(input uart_mem_pkg::byte_t data, input logic bad_stop);
        logic [9:0] frame;
        int         i;
        frame = {~bad_stop, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            rx <= frame[i];
            repeat (cpb) @(posedge clk);
        end
        if (bad_stop) begin
            rx <= 1'b1;                    // idle bit so the next start edge shows
            repeat (cpb) @(posedge clk);
        end
    endtask

    task automatic send_header(input uart_mem_pkg::byte_t cmd, input int addr, input int len);
        send_byte(cmd, 1'b0);
        send_byte(8'(addr >> 8), 1'b0);
        send_byte(8'(addr), 1'b0);
        send_byte(8'(len), 1'b0);
    endtask

    task automatic load_frames();
        int                  fd;
        int                  code;
        int                  addr;
        int                  len;
        int                  aux;
        int                  i;
        logic [63:0]         word;
        logic [1023:0]       line;
        uart_mem_pkg::byte_t b;
        fd = $fopen("test/uart_mem_patterns.txt", "r");
        if (fd == 0) begin
            $display("the pattern file test/uart_mem_patterns.txt could not be opened");
            stop_with_failure();
        end
        code = $fscanf(fd, "%s", word);
        while (code == 1) begin
            if (word[7:0] == "#") begin
                code = $fgets(line, fd);   // skip comment line
            end else begin
                code = $fscanf(fd, "%h %h %h", addr, len, aux);
                kind_q.push_back(word[7:0]);
                addr_q.push_back(addr);
                len_q.push_back(len);
                aux_q.push_back(aux);
                for (i = 0; i < len; i++) begin
                    code = $fscanf(fd, "%h", b);
                    data_q.push_back(b);
                end
            end
            code = $fscanf(fd, "%s", word);
        end
        $fclose(fd);
    endtask

    function automatic int frame_bits(input logic [7:0] kind, input int len);
        int bits;
        case (kind)
            "R":     bits = (4 + 2 * len) * 10;   // header plus reply
            "X":     bits = len * 10;
            default: bits = (5 + len) * 10;
        endcase
        return bits + 32;                         // settle time and longest gap
    endfunction

    // tx decoder, samples near bit centers
    initial begin : tx_monitor
        uart_mem_pkg::byte_t data;
        int                  i;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        forever begin
            @(negedge tx);
            repeat (cpb / 2) @(negedge clk);
            check_equal(32'(tx), 32'd0, "tx start bit");
            for (i = 0; i < 8; i++) begin
                repeat (cpb) @(negedge clk);
                data[i] = tx;
            end
            repeat (cpb) @(negedge clk);
            check_equal(32'(tx), 32'd1, "tx stop bit");
            reply_q.push_back(data);
        end
    end

    always @(negedge clk) begin
        if (!rst && frame_err) begin
            err_count <= err_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("the test ran out of time after %0d cycles", cycles);
            stop_with_failure();
        end
    end

    initial begin
        int total_bits;
        int ptr;
        int f;
        int i;
        int gap;
        int exp_errs;
        rst  = 1'b1;
        rx   = 1'b1;
        void'($urandom(21));
        load_frames();
        total_bits = 0;
        for (f = 0; f < kind_q.size(); f++) begin
            total_bits += frame_bits(kind_q[f], len_q[f]);
        end
        limit = 2 * (total_bits * cpb + 8) + 200;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (cpb) @(posedge clk);
        ptr      = 0;
        exp_errs = 0;
        for (f = 0; f < kind_q.size(); f++) begin
            case (kind_q[f])
                "W": begin
                    send_header(uart_mem_pkg::cmd_write, addr_q[f], len_q[f]);
                    for (i = 0; i < len_q[f]; i++) begin
                        send_byte(data_q[ptr + i], 1'b0);
                    end
                end
                "E": begin
                    send_header(uart_mem_pkg::cmd_write, addr_q[f], len_q[f]);
                    for (i = 0; i < len_q[f]; i++) begin
                        send_byte(data_q[ptr + i], i == aux_q[f]);
                    end
                    exp_errs++;
                end
                "X": begin
                    for (i = 0; i < len_q[f]; i++) begin
                        send_byte(data_q[ptr + i], 1'b0);
                    end
                end
                "R": begin
                    send_header(uart_mem_pkg::cmd_read, addr_q[f], len_q[f]);
                    while (reply_q.size() < len_q[f]) begin
                        @(posedge clk);
                    end
                    for (i = 0; i < len_q[f]; i++) begin
                        check_equal(32'(reply_q.pop_front()), 32'(data_q[ptr + i]),
                                    $sformatf("frame %0d reply byte %0d", f, i));
                    end
                end
                default: begin
                    $display("frame %0d has an unknown kind in the pattern file", f);
                    stop_with_failure();
                end
            endcase
            ptr += len_q[f];
            repeat (12 * cpb) @(posedge clk);    // room for a stray reply byte
            check_equal(reply_q.size(), 0, $sformatf("frame %0d extra tx bytes", f));
            check_equal(err_count, exp_errs, $sformatf("frame %0d frame_err count", f));
            gap = $urandom % 21;
            repeat (gap * cpb) @(posedge clk);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- sources.f
design/uart_mem_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/sram_block.sv
design/mem_loader.sv
design/uart_mem_top.sv
test/uart_mem_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = uart_mem_tb
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- test/uart_mem_patterns.txt
# kind addr len aux bytes, all hex; W write, R read with expected reply,
# X bytes sent raw, E write whose byte number aux has a low stop bit
W 0010 08 00 01 23 45 67 89 ab cd ef
R 0010 08 00 01 23 45 67 89 ab cd ef
W 03fe 04 00 a1 a2 a3 a4
R 0000 02 00 a3 a4
R 03ff 03 00 a2 a3 a4
W 0c40 03 00 5a 5b 5c
R 0040 03 00 5a 5b 5c
R 0440 01 00 5a
W 0010 00 00
R 0010 00 00
R 0010 08 00 01 23 45 67 89 ab cd ef
X 0000 07 00 41 00 10 03 c1 c2 c3
R 0010 08 00 01 23 45 67 89 ab cd ef
W 0020 06 00 e0 e1 e2 e3 e4 e5
E 0020 06 03 11 22 33 44 55 66
R 0020 06 00 11 22 33 e3 e4 e5
R 0010 04 00 01 23 45 67
R 0000 02 00 a3 a4
R 0024 02 00 e4 e5
R 0014 04 00 89 ab cd ef
R 0041 02 00 5b 5c
R 03fe 02 00 a1 a2
